// ==== verilog.f ====
+incdir+.
mem_pkg.sv
mem_arbiter.sv
mem_sram.sv
mem_top.sv
tb_mem_top.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

export_include_dirs:
  - .

sources:
  - mem_pkg.sv
  - mem_arbiter.sv
  - mem_sram.sv
  - mem_top.sv
  - target: simulation
    files:
      - tb_mem_top.sv

// ==== tb_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_defines.svh"

module tb_mem_top import mem_pkg::*; ;

  typedef enum logic [2:0] {
    op_rd,
    op_wr,
    op_rd_pair,
    op_wr_pair,
    op_rd_wr
  } op_e;

  typedef struct packed {
    logic [1:0] master;
    op_e        op;
    addr_t      addr;
    data_t      data;
    strb_t      strb;
    logic [3:0] delay;
    resp_t      resp;
  } entry_t;

  localparam resp_t resp_okay   = resp_t'(`MEM_RESP_OKAY);
  localparam resp_t resp_slverr = resp_t'(`MEM_RESP_SLVERR);
  localparam int    num_fill    = 16;

  logic clk = 1'b0;
  logic rst;

  // Index 1 is the instruction fetch master and index 2 the load/store master
  logic    arvalid [1:2];
  ar_req_t ar      [1:2];
  logic    rready  [1:2];
  logic    awvalid [1:2];
  logic    wvalid  [1:2];
  w_req_t  w       [1:2];
  logic    bready  [1:2];

  logic   m1_arready, m1_rvalid, m1_awready, m1_wready, m1_bvalid;
  logic   m2_arready, m2_rvalid, m2_awready, m2_wready, m2_bvalid;
  r_rsp_t m1_r, m2_r;
  b_rsp_t m1_b, m2_b;

  entry_t      tests [$];
  data_t       shadow [`MEM_WORDS];
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit;

  mem_top dut (
    .m1_arvalid (arvalid[1]),
    .m1_ar      (ar[1]),
    .m1_rready  (rready[1]),
    .m1_awvalid (awvalid[1]),
    .m1_wvalid  (wvalid[1]),
    .m1_w       (w[1]),
    .m1_bready  (bready[1]),
    .m2_arvalid (arvalid[2]),
    .m2_ar      (ar[2]),
    .m2_rready  (rready[2]),
    .m2_awvalid (awvalid[2]),
    .m2_wvalid  (wvalid[2]),
    .m2_w       (w[2]),
    .m2_bready  (bready[2]),
    .*
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, a transaction never completed", cycle_cnt);
      $display("Verification failed");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0d ns: %s = %h, expected %h", $time, name, actual, expected);
      $display("Verification failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic logic request_ready(int m, bit wr);
    if (wr) begin
      return (m == 1) ? (m1_awready && m1_wready) : (m2_awready && m2_wready);
    end
    return (m == 1) ? m1_arready : m2_arready;
  endfunction

  function automatic logic response_valid(int m, bit wr);
    if (wr) begin
      return (m == 1) ? m1_bvalid : m2_bvalid;
    end
    return (m == 1) ? m1_rvalid : m2_rvalid;
  endfunction

  // A write response is returned with zero data so both channels share one shape
  function automatic r_rsp_t response_of(int m, bit wr);
    r_rsp_t rsp;
    if (wr) begin
      rsp.data = '0;
      rsp.resp = (m == 1) ? m1_b.resp : m2_b.resp;
    end else begin
      rsp = (m == 1) ? m1_r : m2_r;
    end
    return rsp;
  endfunction

  function automatic bit in_range(addr_t addr);
    return addr < `MEM_WORDS * 8;
  endfunction

  function automatic data_t expect_read(addr_t addr);
    return in_range(addr) ? shadow[(addr >> 3) % `MEM_WORDS] : '0;
  endfunction

  // Only the strobed bytes of an in-range word change
  function automatic void store_write(addr_t addr, data_t data, strb_t strb);
    int idx;
    idx = (addr >> 3) % `MEM_WORDS;
    if (in_range(addr)) begin
      for (int i = 0; i < `MEM_STRB_W; i++) begin
        if (strb[i]) begin
          shadow[idx][8*i +: 8] = data[8*i +: 8];
        end
      end
    end
  endfunction

  task automatic check_response(input int m, input bit wr, input logic exp_valid,
                                input data_t exp_data, input resp_t exp_resp);
    string  pfx;
    r_rsp_t rsp;
    pfx = $sformatf("m%0d_%s", m, wr ? "b" : "r");
    rsp = response_of(m, wr);
    check_value({pfx, "valid"}, response_valid(m, wr), exp_valid);
    if (!wr) begin
      check_value({pfx, ".data"}, rsp.data, exp_data);
    end
    check_value({pfx, ".resp"}, rsp.resp, exp_resp);
  endtask

  // One read or write on one master with the response held for delay cycles
  task automatic run_txn(input int m, input bit wr, input addr_t addr, input data_t data,
                         input strb_t strb, input int delay, input data_t exp_data,
                         input resp_t exp_resp, output int t_valid, output int t_done);
    @(posedge clk);
    if (wr) begin
      awvalid[m] <= 1'b1;
      wvalid[m]  <= 1'b1;
      w[m].addr  <= addr;
      w[m].data  <= data;
      w[m].strb  <= strb;
    end else begin
      arvalid[m] <= 1'b1;
      ar[m].addr <= addr;
    end
    // Until the grant arrives this master must see an all-zero response
    @(negedge clk);
    while (!request_ready(m, wr)) begin
      check_response(m, wr, 1'b0, '0, '0);
      @(negedge clk);
    end
    @(posedge clk);
    if (wr) begin
      awvalid[m] <= 1'b0;
      wvalid[m]  <= 1'b0;
    end else begin
      arvalid[m] <= 1'b0;
    end
    @(negedge clk);
    while (!response_valid(m, wr)) begin
      @(negedge clk);
    end
    t_valid = cycle_cnt;
    repeat (delay) begin
      check_response(m, wr, 1'b1, exp_data, exp_resp);
      @(negedge clk);
    end
    @(posedge clk);
    if (wr) bready[m] <= 1'b1;
    else rready[m] <= 1'b1;
    @(negedge clk);
    check_response(m, wr, 1'b1, exp_data, exp_resp);
    t_done = cycle_cnt;
    @(posedge clk);
    if (wr) bready[m] <= 1'b0;
    else rready[m] <= 1'b0;
  endtask

  task automatic apply_entry(input entry_t e);
    int    m;
    int    other;
    int    dly;
    int    t_valid [1:2];
    int    t_done  [1:2];
    data_t rd_exp;
    m      = e.master;
    other  = 3 - m;
    dly    = (e.delay == 0) ? 0 : 1 + ($urandom % e.delay);
    rd_exp = expect_read(e.addr);
    case (e.op)
      op_rd: begin
        run_txn(m, 1'b0, e.addr, '0, '0, dly, rd_exp, e.resp, t_valid[m], t_done[m]);
      end
      op_wr: begin
        run_txn(m, 1'b1, e.addr, e.data, e.strb, dly, '0, e.resp, t_valid[m], t_done[m]);
        store_write(e.addr, e.data, e.strb);
      end
      op_rd_pair, op_wr_pair: begin
        fork
          run_txn(1, e.op == op_wr_pair, e.addr, e.data, e.strb, dly, rd_exp, e.resp,
                  t_valid[1], t_done[1]);
          run_txn(2, e.op == op_wr_pair, e.addr, ~e.data, e.strb, dly, rd_exp, e.resp,
                  t_valid[2], t_done[2]);
        join
        // Master 1 wins the tie and master 2 only answers after its release
        check_value("m1_first", t_valid[1] < t_valid[2], 1'b1);
        check_value("m2_after_release", t_done[1] < t_valid[2], 1'b1);
        if (e.op == op_wr_pair) begin
          store_write(e.addr, e.data, e.strb);
          store_write(e.addr, ~e.data, e.strb);
        end
      end
      op_rd_wr: begin
        fork
          run_txn(m, 1'b0, e.addr, '0, '0, dly, rd_exp, e.resp, t_valid[m], t_done[m]);
          run_txn(other, 1'b1, e.addr, e.data, e.strb, dly, '0, e.resp,
                  t_valid[other], t_done[other]);
        join
        store_write(e.addr, e.data, e.strb);
      end
      default: begin
        $display("Unknown operation in test entry");
        $display("Verification failed");
        $fatal(1, "Bad test table");
      end
    endcase
  endtask

  function automatic void add_entry(int master, op_e op, addr_t addr, data_t data,
                                    strb_t strb, int delay, resp_t resp);
    entry_t e;
    e.master = 2'(master);
    e.op     = op;
    e.addr   = addr;
    e.data   = data;
    e.strb   = strb;
    e.delay  = 4'(delay);
    e.resp   = resp;
    tests.push_back(e);
  endfunction

  // Each row gives master, operation, address, write data, strobe, max ready delay and response
  task automatic build_tests();
    add_entry(1, op_wr,      32'h0000, 64'h1122_3344_5566_7788, 8'hff, 0, resp_okay);
    add_entry(2, op_wr,      32'h0008, 64'hdead_beef_cafe_f00d, 8'h0f, 0, resp_okay);
    add_entry(1, op_wr,      32'h0010, 64'ha5a5_5a5a_0f0f_f0f0, 8'ha5, 0, resp_okay);
    add_entry(1, op_rd,      32'h0000, '0, '0, 0, resp_okay);
    add_entry(2, op_rd,      32'h0008, '0, '0, 0, resp_okay);
    add_entry(1, op_rd,      32'h0014, '0, '0, 0, resp_okay);
    add_entry(2, op_rd,      32'h0010, '0, '0, 0, resp_okay);
    add_entry(1, op_rd_pair, 32'h0018, '0, '0, 0, resp_okay);
    add_entry(1, op_wr_pair, 32'h0020, 64'h0123_4567_89ab_cdef, 8'hff, 0, resp_okay);
    add_entry(2, op_rd,      32'h0020, '0, '0, 0, resp_okay);
    add_entry(1, op_rd_wr,   32'h0028, 64'h5555_aaaa_3333_cccc, 8'hff, 0, resp_okay);
    add_entry(2, op_rd_wr,   32'h0030, 64'h7777_8888_9999_0000, 8'hf0, 0, resp_okay);
    add_entry(1, op_rd,      32'h0028, '0, '0, 0, resp_okay);
    add_entry(2, op_rd,      32'h0030, '0, '0, 0, resp_okay);
    add_entry(1, op_rd_pair, 32'h0038, '0, '0, 6, resp_okay);
    add_entry(1, op_wr_pair, 32'h0040, 64'hfeed_face_0bad_c0de, 8'h3c, 5, resp_okay);
    add_entry(2, op_rd,      32'h0040, '0, '0, 4, resp_okay);
    add_entry(1, op_rd_wr,   32'h0048, 64'h1357_9bdf_2468_ace0, 8'h81, 7, resp_okay);
    add_entry(1, op_rd,      32'h0800, '0, '0, 0, resp_slverr);
    add_entry(2, op_wr,      32'h0800, 64'hffff_ffff_ffff_ffff, 8'hff, 3, resp_slverr);
    add_entry(1, op_rd,      32'h0000, '0, '0, 0, resp_okay);
    add_entry(2, op_rd,      32'hffff_fff8, '0, '0, 2, resp_slverr);
    add_entry(1, op_wr,      32'h0001_0000, 64'h0f0f_0f0f_0f0f_0f0f, 8'hff, 0, resp_slverr);
    add_entry(2, op_rd_pair, 32'h0800, '0, '0, 3, resp_slverr);
  endtask

  // Words touched by the table get random contents before the tests start
  task automatic fill_memory();
    data_t fill;
    int    tv;
    int    td;
    for (int i = 0; i < num_fill; i++) begin
      fill = {$urandom, $urandom};
      run_txn(2, 1'b1, addr_t'(i * 8), fill, 8'hff, 0, '0, resp_okay, tv, td);
      store_write(addr_t'(i * 8), fill, 8'hff);
    end
  endtask

  initial begin
    void'($urandom(32'h274cccf6));
    rst = 1'b1;
    for (int m = 1; m <= 2; m++) begin
      arvalid[m] = 1'b0;
      ar[m]      = '0;
      rready[m]  = 1'b0;
      awvalid[m] = 1'b0;
      wvalid[m]  = 1'b0;
      w[m]       = '0;
      bready[m]  = 1'b0;
    end
    build_tests();
    cycle_limit = (tests.size() + num_fill) * 40;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    fill_memory();
    foreach (tests[i]) begin
      apply_entry(tests[i]);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_top import mem_pkg::*; (
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire logic    m1_arvalid,
  input  wire ar_req_t m1_ar,
  output logic         m1_arready,
  output logic         m1_rvalid,
  output r_rsp_t       m1_r,
  input  wire logic    m1_rready,
  input  wire logic    m1_awvalid,
  input  wire logic    m1_wvalid,
  input  wire w_req_t  m1_w,
  output logic         m1_awready,
  output logic         m1_wready,
  output logic         m1_bvalid,
  output b_rsp_t       m1_b,
  input  wire logic    m1_bready,
  input  wire logic    m2_arvalid,
  input  wire ar_req_t m2_ar,
  output logic         m2_arready,
  output logic         m2_rvalid,
  output r_rsp_t       m2_r,
  input  wire logic    m2_rready,
  input  wire logic    m2_awvalid,
  input  wire logic    m2_wvalid,
  input  wire w_req_t  m2_w,
  output logic         m2_awready,
  output logic         m2_wready,
  output logic         m2_bvalid,
  output b_rsp_t       m2_b,
  input  wire logic    m2_bready
);

  // Arbiter to SRAM
  logic    s_arvalid;
  ar_req_t s_ar;
  logic    s_arready;
  logic    s_rvalid;
  r_rsp_t  s_r;
  logic    s_rready;
  logic    s_awvalid;
  logic    s_wvalid;
  w_req_t  s_w;
  logic    s_awready;
  logic    s_wready;
  logic    s_bvalid;
  b_rsp_t  s_b;
  logic    s_bready;

  mem_arbiter u_arbiter (.*);

  mem_sram u_sram (
    .clk     (clk),
    .rst     (rst),
    .arvalid (s_arvalid),
    .ar      (s_ar),
    .arready (s_arready),
    .rvalid  (s_rvalid),
    .r       (s_r),
    .rready  (s_rready),
    .awvalid (s_awvalid),
    .wvalid  (s_wvalid),
    .w       (s_w),
    .awready (s_awready),
    .wready  (s_wready),
    .bvalid  (s_bvalid),
    .b       (s_b),
    .bready  (s_bready)
  );

endmodule

`default_nettype wire

// ==== mem_sram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mem_defines.svh"

module mem_sram import mem_pkg::*; #(
  parameter int READ_LATENCY  = 2,
  parameter int WRITE_LATENCY = 1
) (
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire logic    arvalid,
  input  wire ar_req_t ar,
  output logic         arready,
  output logic         rvalid,
  output r_rsp_t       r,
  input  wire logic    rready,
  input  wire logic    awvalid,
  input  wire logic    wvalid,
  input  wire w_req_t  w,
  output logic         awready,
  output logic         wready,
  output logic         bvalid,
  output b_rsp_t       b,
  input  wire logic    bready
);

  localparam int    IDX_W     = $clog2(`MEM_WORDS);
  localparam int    RD_CNT_W  = (READ_LATENCY > 1) ? $clog2(READ_LATENCY) : 1;
  localparam int    WR_CNT_W  = (WRITE_LATENCY > 1) ? $clog2(WRITE_LATENCY) : 1;
  localparam addr_t MEM_BYTES = addr_t'(`MEM_WORDS * 8);

  data_t mem [`MEM_WORDS];

  sram_state_e         rd_state;
  sram_state_e         wr_state;
  logic [RD_CNT_W-1:0] rd_cnt;
  logic [WR_CNT_W-1:0] wr_cnt;
  logic                wr_rdy;
  r_rsp_t              r_q;
  b_rsp_t              b_q;

  logic             ar_hs;
  logic             wr_hs;
  logic             rd_ok;
  logic             wr_ok;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  assign ar_hs  = arvalid && arready;
  assign wr_hs  = awvalid && wvalid && wr_rdy;
  assign rd_ok  = ar.addr < MEM_BYTES;
  assign wr_ok  = w.addr < MEM_BYTES;
  // Byte offset within the word is dropped
  assign rd_idx = ar.addr[IDX_W+2:3];
  assign wr_idx = w.addr[IDX_W+2:3];

  // Read channel: accept, count down the latency, hold rvalid until rready
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= st_idle;
      rd_cnt   <= '0;
      arready  <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      case (rd_state)
        st_idle: begin
          arready <= 1'b1;
          if (ar_hs) begin
            rd_state <= st_wait;
            rd_cnt   <= RD_CNT_W'(READ_LATENCY - 1);
            arready  <= 1'b0;
          end
        end
        st_wait: begin
          if (rd_cnt == '0) begin
            rd_state <= st_resp;
            rvalid   <= 1'b1;
          end else begin
            rd_cnt <= rd_cnt - 1'b1;
          end
        end
        st_resp: begin
          if (rready) begin
            rd_state <= st_idle;
            rvalid   <= 1'b0;
            arready  <= 1'b1;
          end
        end
        default: begin
          rd_state <= st_idle;
        end
      endcase
    end
  end

  // Data is sampled at the AR handshake, so a write on the same edge is not seen
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      r_q.data <= rd_ok ? mem[rd_idx] : '0;
      r_q.resp <= rd_ok ? resp_t'(`MEM_RESP_OKAY) : resp_t'(`MEM_RESP_SLVERR);
    end
  end

  // Write channel, same shape as the read side
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= st_idle;
      wr_cnt   <= '0;
      wr_rdy   <= 1'b0;
      bvalid   <= 1'b0;
    end else begin
      case (wr_state)
        st_idle: begin
          wr_rdy <= 1'b1;
          if (wr_hs) begin
            wr_state <= st_wait;
            wr_cnt   <= WR_CNT_W'(WRITE_LATENCY - 1);
            wr_rdy   <= 1'b0;
          end
        end
        st_wait: begin
          if (wr_cnt == '0) begin
            wr_state <= st_resp;
            bvalid   <= 1'b1;
          end else begin
            wr_cnt <= wr_cnt - 1'b1;
          end
        end
        st_resp: begin
          if (bready) begin
            wr_state <= st_idle;
            bvalid   <= 1'b0;
            wr_rdy   <= 1'b1;
          end
        end
        default: begin
          wr_state <= st_idle;
        end
      endcase
    end
  end

  // Strobed bytes land on the accepting edge, out-of-range writes are dropped
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      b_q.resp <= wr_ok ? resp_t'(`MEM_RESP_OKAY) : resp_t'(`MEM_RESP_SLVERR);
      if (wr_ok) begin
        for (int i = 0; i < `MEM_STRB_W; i++) begin
          if (w.strb[i]) begin
            mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
          end
        end
      end
    end
  end

  assign awready = wr_rdy;
  assign wready  = wr_rdy;
  assign r       = r_q;
  assign b       = b_q;

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import mem_pkg::*; (
  input  wire logic    clk,
  input  wire logic    rst,
  // Master 1, instruction fetch
  input  wire logic    m1_arvalid,
  input  wire ar_req_t m1_ar,
  output logic         m1_arready,
  output logic         m1_rvalid,
  output r_rsp_t       m1_r,
  input  wire logic    m1_rready,
  input  wire logic    m1_awvalid,
  input  wire logic    m1_wvalid,
  input  wire w_req_t  m1_w,
  output logic         m1_awready,
  output logic         m1_wready,
  output logic         m1_bvalid,
  output b_rsp_t       m1_b,
  input  wire logic    m1_bready,
  // Master 2, load/store
  input  wire logic    m2_arvalid,
  input  wire ar_req_t m2_ar,
  output logic         m2_arready,
  output logic         m2_rvalid,
  output r_rsp_t       m2_r,
  input  wire logic    m2_rready,
  input  wire logic    m2_awvalid,
  input  wire logic    m2_wvalid,
  input  wire w_req_t  m2_w,
  output logic         m2_awready,
  output logic         m2_wready,
  output logic         m2_bvalid,
  output b_rsp_t       m2_b,
  input  wire logic    m2_bready,
  // Slave side
  output logic         s_arvalid,
  output ar_req_t      s_ar,
  input  wire logic    s_arready,
  input  wire logic    s_rvalid,
  input  wire r_rsp_t  s_r,
  output logic         s_rready,
  output logic         s_awvalid,
  output logic         s_wvalid,
  output w_req_t       s_w,
  input  wire logic    s_awready,
  input  wire logic    s_wready,
  input  wire logic    s_bvalid,
  input  wire b_rsp_t  s_b,
  output logic         s_bready
);

  grant_e rd_grant;
  grant_e wr_grant;

  // Read owner, released on the R handshake so no response is dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_grant <= grant_idle;
    end else begin
      case (rd_grant)
        grant_idle: begin
          if (m1_arvalid) begin
            rd_grant <= grant_m1;
          end else if (m2_arvalid) begin
            rd_grant <= grant_m2;
          end
        end
        grant_m1, grant_m2: begin
          if (s_rvalid && s_rready) begin
            rd_grant <= grant_idle;
          end
        end
        default: begin
          rd_grant <= grant_idle;
        end
      endcase
    end
  end

  // Write owner, needs address and data together and is held until B completes
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_grant <= grant_idle;
    end else begin
      case (wr_grant)
        grant_idle: begin
          if (m1_awvalid && m1_wvalid) begin
            wr_grant <= grant_m1;
          end else if (m2_awvalid && m2_wvalid) begin
            wr_grant <= grant_m2;
          end
        end
        grant_m1, grant_m2: begin
          if (s_bvalid && s_bready) begin
            wr_grant <= grant_idle;
          end
        end
        default: begin
          wr_grant <= grant_idle;
        end
      endcase
    end
  end

  // Owner's read request goes to the slave, nothing else gets through
  always_comb begin
    s_arvalid = 1'b0;
    s_ar      = '0;
    s_rready  = 1'b0;
    case (rd_grant)
      grant_m1: begin
        s_arvalid = m1_arvalid;
        s_ar      = m1_ar;
        s_rready  = m1_rready;
      end
      grant_m2: begin
        s_arvalid = m2_arvalid;
        s_ar      = m2_ar;
        s_rready  = m2_rready;
      end
      default: ;
    endcase
  end

  always_comb begin
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    s_w       = '0;
    s_bready  = 1'b0;
    case (wr_grant)
      grant_m1: begin
        s_awvalid = m1_awvalid;
        s_wvalid  = m1_wvalid;
        s_w       = m1_w;
        s_bready  = m1_bready;
      end
      grant_m2: begin
        s_awvalid = m2_awvalid;
        s_wvalid  = m2_wvalid;
        s_w       = m2_w;
        s_bready  = m2_bready;
      end
      default: ;
    endcase
  end

  // Ungranted masters see zeros on every response signal
  assign m1_arready = (rd_grant == grant_m1) ? s_arready : 1'b0;
  assign m1_rvalid  = (rd_grant == grant_m1) ? s_rvalid  : 1'b0;
  assign m1_r       = (rd_grant == grant_m1) ? s_r       : '0;

  assign m2_arready = (rd_grant == grant_m2) ? s_arready : 1'b0;
  assign m2_rvalid  = (rd_grant == grant_m2) ? s_rvalid  : 1'b0;
  assign m2_r       = (rd_grant == grant_m2) ? s_r       : '0;

  assign m1_awready = (wr_grant == grant_m1) ? s_awready : 1'b0;
  assign m1_wready  = (wr_grant == grant_m1) ? s_wready  : 1'b0;
  assign m1_bvalid  = (wr_grant == grant_m1) ? s_bvalid  : 1'b0;
  assign m1_b       = (wr_grant == grant_m1) ? s_b       : '0;

  assign m2_awready = (wr_grant == grant_m2) ? s_awready : 1'b0;
  assign m2_wready  = (wr_grant == grant_m2) ? s_wready  : 1'b0;
  assign m2_bvalid  = (wr_grant == grant_m2) ? s_bvalid  : 1'b0;
  assign m2_b       = (wr_grant == grant_m2) ? s_b       : '0;

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

`include "mem_defines.svh"

package mem_pkg;

  typedef logic [`MEM_ADDR_W-1:0] addr_t;
  typedef logic [`MEM_DATA_W-1:0] data_t;
  typedef logic [`MEM_STRB_W-1:0] strb_t;
  typedef logic [1:0]             resp_t;

  // Read address channel
  typedef struct packed {
    addr_t addr;
  } ar_req_t;

  // Read data channel
  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_rsp_t;

  // Write address and data travel together
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } w_req_t;

  // Write response channel
  typedef struct packed {
    resp_t resp;
  } b_rsp_t;

  // Channel owner in the arbiter
  typedef enum logic [1:0] {
    grant_idle,
    grant_m1,
    grant_m2
  } grant_e;

  // Per-channel states of the SRAM slave
  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_resp
  } sram_state_e;

endpackage

`default_nettype wire

// ==== mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Bus widths shared by both masters and the SRAM port
`define MEM_ADDR_W 32
`define MEM_DATA_W 64
`define MEM_STRB_W 8

// SRAM depth in 64-bit words, also the limit of the range check
`define MEM_WORDS 256

// Response codes returned on R and B
`define MEM_RESP_OKAY   0
`define MEM_RESP_SLVERR 2

`endif
